/* video_board.f */
+incdir+include
rtl/video_pkg.sv
rtl/video_timing.sv
rtl/cpu_regs.sv
rtl/tile_layer.sv
rtl/priority_mixer.sv
rtl/palette_lut.sv
rtl/video_board.sv
sim/video_board_asserts.sv
sim/video_board_tb.sv

/* Bender.yml */
package:
  name: video_board

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/video_pkg.sv
      - rtl/video_timing.sv
      - rtl/cpu_regs.sv
      - rtl/tile_layer.sv
      - rtl/priority_mixer.sv
      - rtl/palette_lut.sv
      - rtl/video_board.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/video_board_asserts.sv
      - sim/video_board_tb.sv

/* sim/video_board_tb.sv */
`include "video_consts.svh"

module video_board_tb import video_pkg::*; ;

	timeunit 1ns;
	timeprecision 1ps;

	// one frame of pixel slots at 100 ns per clock
	localparam longint FRAME_NS = `H_TOTAL * `V_TOTAL * `PIX_DIV * 100;
	// five captured frames, each may wait up to one frame for its start
	localparam int RUN_FRAMES = 12;
	localparam longint WATCH_NS = (RUN_FRAMES + 2) * FRAME_NS;

	logic clk_48m;
	logic rst_n;
	cpu_addr_t cpu_addr;
	cpu_data_t cpu_data;
	logic cpu_wr;
	logic vid_pix_en;
	rgb_t vid_data;
	logic vid_hsync_n;
	logic vid_vsync_n;
	logic vid_hblank_n;
	logic vid_vblank_n;

	int checks;
	int errors;
	logic [31:0] lfsr_state;

	// reference model of the board state
	logic [6:0] tile_model [2][`TILE_ENTRIES];
	logic [11:0] pal_model [`PAL_ENTRIES];
	logic [4:0] scroll_model [4];
	logic [2:0] ctrl_model;
	logic [6:0] back_model;

	video_board video_board_inst (.*);

	always #50 clk_48m = ~clk_48m;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		// taps 32 22 2 1
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[6:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic compare(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error: %0d ns %s got %0h expected %0h", $time, name, actual, expected);
		end
	endtask

	// one cpu_wr strobe, driven 10 ns after the edge
	task automatic cpu_write(input cpu_addr_t addr, input cpu_data_t data);
		@(posedge clk_48m);
		#10;
		cpu_addr = addr;
		cpu_data = data;
		cpu_wr = 1'b1;
		@(posedge clk_48m);
		#10;
		cpu_wr = 1'b0;
	endtask

	task automatic load_tile(input int layer, input int idx, input cpu_data_t data);
		cpu_write((layer ? `ADDR_TILE1 : `ADDR_TILE0) + 10'(idx), data);
		tile_model[layer][idx] = data[6:0];
	endtask

	// even byte green and red, odd byte blue
	task automatic set_palette_byte(input int off, input cpu_data_t data);
		cpu_write(`ADDR_PAL + 10'(off), data);
		if (off % 2) begin
			pal_model[off / 2][11:8] = data[3:0];
		end else begin
			pal_model[off / 2][7:0] = data;
		end
	endtask

	task automatic set_register(input int off, input cpu_data_t data);
		cpu_write(`ADDR_REGS + 10'(off), data);
		case (off)
			`REG_CTRL: ctrl_model = data[2:0];
			`REG_BACKCOLOR: back_model = data[6:0];
			default: scroll_model[off] = data[4:0];
		endcase
	endtask

	// expected colour of active pixel x, y
	function automatic rgb_t expected_rgb(input int x, input int y);
		int sx;
		int sy;
		logic [6:0] d [2];
		logic [6:0] front;
		logic [6:0] back;
		logic [6:0] sel;
		for (int l = 0; l < 2; l++) begin
			sx = (x + scroll_model[2 * l]) % 32;
			sy = (y + scroll_model[2 * l + 1]) % 32;
			// ctrl bit 1 and 2 turn a layer off
			d[l] = ctrl_model[l + 1] ? 7'd0 : tile_model[l][(sy / 4) * 8 + sx / 4];
		end
		front = ctrl_model[0] ? d[1] : d[0];
		back = ctrl_model[0] ? d[0] : d[1];
		if (front != 0) begin
			sel = front;
		end else if (back != 0) begin
			sel = back;
		end else begin
			sel = back_model;
		end
		return pal_model[sel];
	endfunction

	// outputs are steady at the falling edge inside a strobe
	task automatic step_slot();
		do @(negedge clk_48m); while (vid_pix_en !== 1'b1);
	endtask

	task automatic find_frame_start();
		logic prev_v;
		prev_v = vid_vblank_n;
		step_slot();
		while (!(prev_v && !vid_vblank_n)) begin
			prev_v = vid_vblank_n;
			step_slot();
		end
	endtask

	////////////////////////////////////////
	// frame capture
	////////////////////////////////////////

	// checks timing and every active pixel of one frame
	task automatic capture_frame();
		int slots;
		int line;
		int col;
		int all_lines;
		int hs_last;
		int vline;
		logic prev_h;
		logic prev_v;
		logic prev_hs;
		slots = 0;
		line = 0;
		col = 0;
		all_lines = 0;
		hs_last = -1;
		find_frame_start();
		prev_h = vid_hblank_n;
		prev_v = vid_vblank_n;
		prev_hs = vid_hsync_n;
		forever begin
			step_slot();
			slots++;
			// next frame begins
			if (prev_v && !vid_vblank_n) break;
			// line of this slot, slot 0 was the first line of vertical blank
			vline = (`V_ACTIVE + slots / `H_TOTAL) % `V_TOTAL;
			compare("vid_vsync_n", vid_vsync_n,
				!((vline >= `V_SYNC_START) && (vline < `V_SYNC_END)));
			if (prev_hs && !vid_hsync_n) begin
				if (hs_last >= 0) begin
					compare("slots between vid_hsync_n falls", slots - hs_last, `H_TOTAL);
				end
				hs_last = slots;
			end
			if (prev_h && !vid_hblank_n) begin
				all_lines++;
				if (vid_vblank_n) begin
					compare("active pixels in line", col, `H_ACTIVE);
					line++;
					col = 0;
				end
			end
			if (vid_hblank_n && vid_vblank_n) begin
				compare("vid_data", vid_data, expected_rgb(col, line));
				col++;
			end else begin
				compare("vid_data in blank", vid_data, 0);
			end
			prev_h = vid_hblank_n;
			prev_v = vid_vblank_n;
			prev_hs = vid_hsync_n;
		end
		compare("slots per frame", slots, `H_TOTAL * `V_TOTAL);
		compare("lines per frame", all_lines, `V_TOTAL);
		compare("active lines per frame", line, `V_ACTIVE);
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic reset_state();
		compare("vid_data", vid_data, 0);
		compare("{hsync_n,vsync_n,hblank_n,vblank_n}",
			{vid_hsync_n, vid_vsync_n, vid_hblank_n, vid_vblank_n}, 4'hf);
		// first line is active, nothing asserted yet
		repeat (`H_ACTIVE) begin
			step_slot();
			compare("vid_data", vid_data, 0);
			compare("{hsync_n,vsync_n,hblank_n,vblank_n}",
				{vid_hsync_n, vid_vsync_n, vid_hblank_n, vid_vblank_n}, 4'hf);
		end
	endtask

	// random tiles with about a quarter transparent
	task automatic fill_memories();
		for (int l = 0; l < 2; l++) begin
			for (int i = 0; i < `TILE_ENTRIES; i++) begin
				load_tile(l, i, (rand_bits(2) == 0) ? 8'h00 : rand_bits(8));
			end
		end
		for (int i = 0; i < 2 * `PAL_ENTRIES; i++) begin
			set_palette_byte(i, rand_bits(8));
		end
		set_register(`REG_BACKCOLOR, rand_bits(8));
		// outside the map, must not land anywhere
		cpu_write(10'h100, 8'hff);
		cpu_write(`ADDR_REGS + 10'd6, 8'hff);
	endtask

	task automatic single_layer_scroll();
		set_register(`REG_CTRL, 8'h04);
		set_register(`REG_SCROLL_X0, rand_bits(8));
		set_register(`REG_SCROLL_Y0, rand_bits(8));
		capture_frame();
	endtask

	task automatic layer_priority();
		set_register(`REG_SCROLL_X1, rand_bits(8));
		set_register(`REG_SCROLL_Y1, rand_bits(8));
		// layer 0 in front, then layer 1
		set_register(`REG_CTRL, 8'h00);
		capture_frame();
		set_register(`REG_CTRL, 8'h01);
		capture_frame();
	endtask

	task automatic background_palette();
		set_register(`REG_CTRL, 8'h06);
		capture_frame();
		set_palette_byte(2 * back_model, rand_bits(8));
		set_palette_byte(2 * back_model + 1, rand_bits(8));
		capture_frame();
	endtask

	////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////

	initial begin
		clk_48m = 1'b0;
		rst_n = 1'b1;
		cpu_addr = '0;
		cpu_data = '0;
		cpu_wr = 1'b0;
		checks = 0;
		errors = 0;
		lfsr_state = 32'hd37d2c9a;
		for (int i = 0; i < `TILE_ENTRIES; i++) begin
			tile_model[0][i] = '0;
			tile_model[1][i] = '0;
		end
		for (int i = 0; i < `PAL_ENTRIES; i++) begin
			pal_model[i] = '0;
		end
		for (int i = 0; i < 4; i++) begin
			scroll_model[i] = '0;
		end
		ctrl_model = '0;
		back_model = '0;
		repeat (16) @(posedge clk_48m);
		#10;
		rst_n = 1'b0;
		reset_state();
		fill_memories();
		single_layer_scroll();
		layer_priority();
		background_palette();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#(WATCH_NS);
		$display("Timeout: the tests did not finish in %0d frames", RUN_FRAMES + 2);
		$display("Verification failed");
		$finish;
	end

endmodule

/* sim/video_board_asserts.sv */
module video_board_asserts import video_pkg::*; (
	input logic clk_48m,
	input logic rst_n,
	input logic vid_pix_en,
	input rgb_t vid_data,
	input logic vid_hsync_n,
	input logic vid_hblank_n,
	input logic vid_vblank_n
);

	timeunit 1ns;
	timeprecision 1ps;

	////////////////////////////////////////
	// output timing rules
	////////////////////////////////////////

	// hsync sits inside horizontal blank
	hsync_in_blank: assert property (@(posedge clk_48m) disable iff (rst_n)
		!vid_hsync_n |-> !vid_hblank_n)
		else $error("vid_hsync_n low outside horizontal blank");

	// black during any blank
	data_black_in_blank: assert property (@(posedge clk_48m) disable iff (rst_n)
		(!vid_hblank_n || !vid_vblank_n) |-> (vid_data == '0))
		else $error("vid_data not zero during blank");

	// strobe is a single clock wide
	pix_en_single: assert property (@(posedge clk_48m) disable iff (rst_n)
		vid_pix_en |=> !vid_pix_en)
		else $error("vid_pix_en high on two consecutive cycles");

endmodule

bind video_board video_board_asserts video_board_asserts_inst (.*);

/* rtl/video_board.sv */
module video_board import video_pkg::*; (
	input  logic      clk_48m,
	input  logic      rst_n,
	// cpu write bus
	input  cpu_addr_t cpu_addr,
	input  cpu_data_t cpu_data,
	input  logic      cpu_wr,
	// video out
	output logic      vid_pix_en,
	output rgb_t      vid_data,
	output logic      vid_hsync_n,
	output logic      vid_vsync_n,
	output logic      vid_hblank_n,
	output logic      vid_vblank_n
);

	logic pix_en;
	beam_t beam;
	sync_t sync;
	mem_wr_t tile_wr0;
	mem_wr_t tile_wr1;
	mem_wr_t pal_wr;
	layer_cfg_t cfg0;
	layer_cfg_t cfg1;
	mix_cfg_t mix;
	dot_t dot0;
	dot_t dot1;
	dot_t mix_dot;
	// beam active through the layer stage
	logic active_d;
	logic mix_active;
	rgb_t rgb;

	////////////////////////////////////////
	// timing and cpu side
	////////////////////////////////////////

	video_timing video_timing_inst (
		.clk_48m (clk_48m),
		.rst_n   (rst_n),
		.pix_en  (pix_en),
		.beam    (beam),
		.sync    (sync)
	);

	cpu_regs cpu_regs_inst (
		.clk_48m  (clk_48m),
		.rst_n    (rst_n),
		.cpu_addr (cpu_addr),
		.cpu_data (cpu_data),
		.cpu_wr   (cpu_wr),
		.tile_wr0 (tile_wr0),
		.tile_wr1 (tile_wr1),
		.pal_wr   (pal_wr),
		.cfg0     (cfg0),
		.cfg1     (cfg1),
		.mix      (mix)
	);

	////////////////////////////////////////
	// pixel datapath
	////////////////////////////////////////

	tile_layer layer0 (
		.clk_48m (clk_48m),
		.rst_n   (rst_n),
		.pix_en  (pix_en),
		.beam    (beam),
		.cfg     (cfg0),
		.tile_wr (tile_wr0),
		.dot     (dot0)
	);

	tile_layer layer1 (
		.clk_48m (clk_48m),
		.rst_n   (rst_n),
		.pix_en  (pix_en),
		.beam    (beam),
		.cfg     (cfg1),
		.tile_wr (tile_wr1),
		.dot     (dot1)
	);

	// same slot as the layer dots
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			active_d <= 1'b0;
		end else if (pix_en) begin
			active_d <= beam.active;
		end
	end

	priority_mixer priority_mixer_inst (
		.clk_48m    (clk_48m),
		.rst_n      (rst_n),
		.pix_en     (pix_en),
		.dot0       (dot0),
		.dot1       (dot1),
		.active     (active_d),
		.mix        (mix),
		.dot        (mix_dot),
		.dot_active (mix_active)
	);

	palette_lut palette_lut_inst (
		.clk_48m    (clk_48m),
		.rst_n      (rst_n),
		.pix_en     (pix_en),
		.pal_wr     (pal_wr),
		.dot        (mix_dot),
		.dot_active (mix_active),
		.rgb        (rgb)
	);

	// outputs
	assign vid_pix_en = pix_en;
	assign vid_data = rgb;
	assign vid_hsync_n = sync.hsync_n;
	assign vid_vsync_n = sync.vsync_n;
	assign vid_hblank_n = sync.hblank_n;
	assign vid_vblank_n = sync.vblank_n;

endmodule

/* rtl/palette_lut.sv */
`include "video_consts.svh"

module palette_lut import video_pkg::*; (
	input  logic    clk_48m,
	input  logic    rst_n,
	input  logic    pix_en,
	input  mem_wr_t pal_wr,
	input  dot_t    dot,
	input  logic    dot_active,
	output rgb_t    rgb
);

	rgb_t pal_ram [`PAL_ENTRIES];
	// two bytes per entry
	dot_t pal_idx;

	assign pal_idx = pal_wr.addr[7:1];

	////////////////////////////////////////
	// byte-wise cpu writes
	////////////////////////////////////////

	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			for (int i = 0; i < `PAL_ENTRIES; i++) begin
				pal_ram[i] <= '0;
			end
		end else if (pal_wr.en) begin
			if (pal_wr.addr[0]) begin
				// odd byte, blue in low nibble
				pal_ram[pal_idx][11:8] <= pal_wr.data[3:0];
			end else begin
				// even byte, green high and red low
				pal_ram[pal_idx][7:0] <= pal_wr.data;
			end
		end
	end

	// stage 3
	// black outside the active area
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			rgb <= '0;
		end else if (pix_en) begin
			if (dot_active) begin
				rgb <= pal_ram[dot];
			end else begin
				rgb <= '0;
			end
		end
	end

endmodule

/* rtl/priority_mixer.sv */
module priority_mixer import video_pkg::*; (
	input  logic     clk_48m,
	input  logic     rst_n,
	input  logic     pix_en,
	input  dot_t     dot0,
	input  dot_t     dot1,
	input  logic     active,
	input  mix_cfg_t mix,
	output dot_t     dot,
	output logic     dot_active
);

	dot_t front_dot;
	dot_t back_dot;
	dot_t sel_dot;

	always_comb begin
		// layer order from ctrl bit 0
		if (mix.layer1_front) begin
			front_dot = dot1;
			back_dot = dot0;
		end else begin
			front_dot = dot0;
			back_dot = dot1;
		end
		// zero falls through to the next layer
		if (front_dot != '0) begin
			sel_dot = front_dot;
		end else if (back_dot != '0) begin
			sel_dot = back_dot;
		end else begin
			sel_dot = mix.backcolor;
		end
	end

	// stage 2
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			dot <= '0;
			dot_active <= 1'b0;
		end else if (pix_en) begin
			dot <= sel_dot;
			dot_active <= active;
		end
	end

endmodule

/* rtl/tile_layer.sv */
`include "video_consts.svh"

module tile_layer import video_pkg::*; (
	input  logic       clk_48m,
	input  logic       rst_n,
	input  logic       pix_en,
	input  beam_t      beam,
	input  layer_cfg_t cfg,
	input  mem_wr_t    tile_wr,
	output dot_t       dot
);

	// each entry is the colour index itself
	dot_t tile_ram [`TILE_ENTRIES];
	scroll_t sum_x;
	scroll_t sum_y;
	tile_idx_t idx;

	////////////////////////////////////////
	// tile ram
	////////////////////////////////////////

	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			for (int i = 0; i < `TILE_ENTRIES; i++) begin
				tile_ram[i] <= '0;
			end
		end else if (tile_wr.en) begin
			tile_ram[tile_idx_t'(tile_wr.addr)] <= tile_wr.data[6:0];
		end
	end

	////////////////////////////////////////
	// scrolled lookup
	////////////////////////////////////////

	// 5 bit sums wrap over the plane
	assign sum_x = beam.x[4:0] + cfg.scroll_x;
	assign sum_y = beam.y + cfg.scroll_y;

	// row times 8 plus column, 4 pixels per tile
	assign idx = {sum_y[4:2], sum_x[4:2]};

	// stage 1
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			dot <= '0;
		end else if (pix_en) begin
			// disabled layer reads as transparent
			if (cfg.enable) begin
				dot <= tile_ram[idx];
			end else begin
				dot <= '0;
			end
		end
	end

endmodule

/* rtl/cpu_regs.sv */
`include "video_consts.svh"

module cpu_regs import video_pkg::*; (
	input  logic       clk_48m,
	input  logic       rst_n,
	input  cpu_addr_t  cpu_addr,
	input  cpu_data_t  cpu_data,
	input  logic       cpu_wr,
	output mem_wr_t    tile_wr0,
	output mem_wr_t    tile_wr1,
	output mem_wr_t    pal_wr,
	output layer_cfg_t cfg0,
	output layer_cfg_t cfg1,
	output mix_cfg_t   mix
);

	localparam cpu_addr_t TILE0_BASE = `ADDR_TILE0;
	localparam cpu_addr_t TILE1_BASE = `ADDR_TILE1;
	localparam cpu_addr_t PAL_BASE = `ADDR_PAL;
	localparam cpu_addr_t REGS_BASE = `ADDR_REGS;

	logic hit_tile0;
	logic hit_tile1;
	logic hit_pal;
	logic hit_regs;
	scroll_t scroll_x0;
	scroll_t scroll_y0;
	scroll_t scroll_x1;
	scroll_t scroll_y1;
	// bit 0 layer1 front, bit 1 and 2 layer disables
	logic [2:0] ctrl;
	dot_t backcolor;

	// address decode
	// 64 bytes per tile ram, 256 for palette, 8 for regs
	assign hit_tile0 = (cpu_addr[9:6] == TILE0_BASE[9:6]);
	assign hit_tile1 = (cpu_addr[9:6] == TILE1_BASE[9:6]);
	assign hit_pal = (cpu_addr[9:8] == PAL_BASE[9:8]);
	assign hit_regs = (cpu_addr[9:3] == REGS_BASE[9:3]);

	// ram strobes take effect on this same edge
	always_comb begin
		tile_wr0.en = cpu_wr && hit_tile0;
		tile_wr0.addr = {2'b00, cpu_addr[5:0]};
		tile_wr0.data = cpu_data;
		tile_wr1.en = cpu_wr && hit_tile1;
		tile_wr1.addr = {2'b00, cpu_addr[5:0]};
		tile_wr1.data = cpu_data;
		// byte offset into the palette
		pal_wr.en = cpu_wr && hit_pal;
		pal_wr.addr = cpu_addr[7:0];
		pal_wr.data = cpu_data;
	end

	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			scroll_x0 <= '0;
			scroll_y0 <= '0;
			scroll_x1 <= '0;
			scroll_y1 <= '0;
			ctrl <= '0;
			backcolor <= '0;
		end else if (cpu_wr && hit_regs) begin
			case (cpu_addr[2:0])
				`REG_SCROLL_X0: scroll_x0 <= cpu_data[4:0];
				`REG_SCROLL_Y0: scroll_y0 <= cpu_data[4:0];
				`REG_SCROLL_X1: scroll_x1 <= cpu_data[4:0];
				`REG_SCROLL_Y1: scroll_y1 <= cpu_data[4:0];
				`REG_CTRL: ctrl <= cpu_data[2:0];
				`REG_BACKCOLOR: backcolor <= cpu_data[6:0];
				// offsets 6 and 7 unmapped
				default: ;
			endcase
		end
	end

	// disable bits become enables
	assign cfg0 = '{scroll_x: scroll_x0, scroll_y: scroll_y0, enable: !ctrl[1]};
	assign cfg1 = '{scroll_x: scroll_x1, scroll_y: scroll_y1, enable: !ctrl[2]};
	assign mix = '{layer1_front: ctrl[0], backcolor: backcolor};

endmodule

/* rtl/video_timing.sv */
`include "video_consts.svh"

module video_timing import video_pkg::*; (
	input  logic  clk_48m,
	input  logic  rst_n,
	output logic  pix_en,
	output beam_t beam,
	output sync_t sync
);

	localparam int DIV_W = $clog2(`PIX_DIV);

	logic [DIV_W-1:0] div_cnt;
	hpos_t h_cnt;
	vpos_t v_cnt;
	sync_t sync_now;
	// oldest entry sits at the top
	sync_t [`PIPE_DEPTH-1:0] sync_pipe;

	////////////////////////////////////////
	// pixel slot divider
	////////////////////////////////////////

	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			div_cnt <= '0;
			pix_en <= 1'b0;
		end else begin
			if (div_cnt == DIV_W'(`PIX_DIV - 1)) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			// one clock out of every PIX_DIV
			pix_en <= (div_cnt == DIV_W'(`PIX_DIV - 1));
		end
	end

	////////////////////////////////////////
	// beam counters
	////////////////////////////////////////

	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (pix_en) begin
			if (h_cnt == hpos_t'(`H_TOTAL - 1)) begin
				h_cnt <= '0;
				// end of line steps the line counter
				if (v_cnt == vpos_t'(`V_TOTAL - 1)) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// stage 0 beam and raw sync from the counts
	always_comb begin
		beam.x = h_cnt;
		beam.y = v_cnt;
		beam.active = (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);
		sync_now.hsync_n = !((h_cnt >= `H_SYNC_START) && (h_cnt < `H_SYNC_END));
		sync_now.vsync_n = !((v_cnt >= `V_SYNC_START) && (v_cnt < `V_SYNC_END));
		sync_now.hblank_n = (h_cnt < `H_ACTIVE);
		sync_now.vblank_n = (v_cnt < `V_ACTIVE);
	end

	// delay sync by the datapath depth
	// all ones is the inactive level
	always_ff @(posedge clk_48m) begin
		if (rst_n) begin
			sync_pipe <= '1;
		end else if (pix_en) begin
			sync_pipe <= {sync_pipe[`PIPE_DEPTH-2:0], sync_now};
		end
	end

	assign sync = sync_pipe[`PIPE_DEPTH-1];

endmodule

/* rtl/video_pkg.sv */
package video_pkg;

	////////////////////////////////////////
	// plain vector types
	////////////////////////////////////////

	// beam counters
	typedef logic [5:0] hpos_t;
	typedef logic [4:0] vpos_t;
	// scroll offset, wraps over the 32x32 plane
	typedef logic [4:0] scroll_t;
	// 8x8 tiles of 4x4 pixels
	typedef logic [5:0] tile_idx_t;
	// colour index, zero is transparent
	typedef logic [6:0] dot_t;
	// blue [11:8], green [7:4], red [3:0]
	typedef logic [11:0] rgb_t;
	// cpu bus
	typedef logic [9:0] cpu_addr_t;
	typedef logic [7:0] cpu_data_t;

	////////////////////////////////////////
	// grouped signals
	////////////////////////////////////////

	// undelayed beam position
	typedef struct packed {
		hpos_t x;
		vpos_t y;
		logic  active;
	} beam_t;

	// delayed to line up with vid_data
	typedef struct packed {
		logic hsync_n;
		logic vsync_n;
		logic hblank_n;
		logic vblank_n;
	} sync_t;

	typedef struct packed {
		scroll_t scroll_x;
		scroll_t scroll_y;
		logic    enable;
	} layer_cfg_t;

	typedef struct packed {
		logic layer1_front;
		dot_t backcolor;
	} mix_cfg_t;

	// single-cycle ram write strobe
	typedef struct packed {
		logic       en;
		logic [7:0] addr;
		cpu_data_t  data;
	} mem_wr_t;

endpackage

/* include/video_consts.svh */
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

////////////////////////////////////////
// screen geometry
////////////////////////////////////////

// horizontal, in pixel slots
`define H_ACTIVE 32
`define H_TOTAL 40
`define H_SYNC_START 34
`define H_SYNC_END 36

// vertical, in lines
`define V_ACTIVE 16
`define V_TOTAL 20
`define V_SYNC_START 17
`define V_SYNC_END 18

// master clocks per pixel slot
`define PIX_DIV 8

// slots from beam position to rgb out
`define PIPE_DEPTH 3

// ram sizes
`define TILE_ENTRIES 64
`define PAL_ENTRIES 128

////////////////////////////////////////
// cpu address map
////////////////////////////////////////

`define ADDR_TILE0 10'h000
`define ADDR_TILE1 10'h040
`define ADDR_PAL 10'h200
`define ADDR_REGS 10'h300

// register offsets within ADDR_REGS
`define REG_SCROLL_X0 3'd0
`define REG_SCROLL_Y0 3'd1
`define REG_SCROLL_X1 3'd2
`define REG_SCROLL_Y1 3'd3
`define REG_CTRL 3'd4
`define REG_BACKCOLOR 3'd5

`endif
